// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_taint_shadow
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf $(OBJ_DIR)

// File: taint_exec.sv
`timescale 1ns/1ps

module taint_exec (
    input  logic                         pos_clk,
    input  logic                         pos_arst,
    input  logic                         op_valid,
    input  logic [taint_pkg::op_w-1:0]   op,
    input  logic [taint_pkg::data_w-1:0] a,
    input  logic [taint_pkg::data_w-1:0] b,
    input  logic [taint_pkg::data_w-1:0] a_taint,
    input  logic [taint_pkg::data_w-1:0] b_taint,
    input  logic                         sel,
    input  logic                         sel_taint,
    input  logic                         en_taint,
    output logic [taint_pkg::data_w-1:0] res,
    output logic [taint_pkg::data_w-1:0] res_taint
);

    logic [taint_pkg::data_w-1:0] y;
    logic [taint_pkg::data_w-1:0] y_taint;
    logic [taint_pkg::data_w-1:0] both_taint;
    logic [taint_pkg::data_w-1:0] a_lo, a_hi;
    logic [taint_pkg::data_w-1:0] b_lo, b_hi;
    logic [taint_pkg::data_w-1:0] en_diff;

    // bounds with tainted bits forced low or high
    assign a_lo = a & ~a_taint;
    assign b_lo = b & ~b_taint;
    assign a_hi = a | a_taint;
    assign b_hi = b | b_taint;
    assign both_taint = a_taint | b_taint;

    always_comb begin
        y = '0;
        y_taint = '0;
        case (op)
            taint_pkg::op_and: begin
                y = a & b;
                y_taint = (a_taint & b) | (b_taint & a) | (a_taint & b_taint);
            end
            taint_pkg::op_or: begin
                y = a | b;
                y_taint = (a_taint & ~b) | (b_taint & ~a) | (a_taint & b_taint);
            end
            taint_pkg::op_add: begin
                y = a + b;
                y_taint = ((a_lo + b_lo) ^ (a_hi + b_hi)) | both_taint;
            end
            taint_pkg::op_sub: begin
                y = a - b;
                y_taint = ((a_lo - b_lo) ^ (a_hi - b_hi)) | both_taint;
            end
            taint_pkg::op_shl: begin
                y = a << b;
                y_taint = (|b_taint) ? '1 : (a_taint << b);
            end
            taint_pkg::op_shr: begin
                y = a >> b;
                y_taint = (|b_taint) ? '1 : (a_taint >> b);
            end
            taint_pkg::op_eq: begin
                y = {{(taint_pkg::data_w-1){1'b0}}, a == b};
                // only the untainted bits can decide the compare
                y_taint = {{(taint_pkg::data_w-1){1'b0}},
                           (|both_taint) && ((a & ~both_taint) == (b & ~both_taint))};
            end
            default: begin
                y = sel ? b : a;
                y_taint = sel ? b_taint : a_taint;
                // a tainted select exposes every differing bit
                if (sel_taint) begin
                    y_taint = y_taint | (a ^ b);
                end
            end
        endcase
    end

    // bits that would differ had the enable gone the other way
    assign en_diff = en_taint ? (y ^ res) : '0;

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            res <= '0;
            res_taint <= '0;
        end else if (op_valid) begin
            res <= y;
            res_taint <= y_taint | en_diff;
        end else begin
            res_taint <= res_taint | en_diff;
        end
    end

    a_op_known: assert property (@(posedge pos_clk) disable iff (pos_arst)
        op_valid |-> !$isunknown(op));

endmodule

// File: taint_mem.sv
`timescale 1ns/1ps

module taint_mem (
    input  logic                         pos_clk,
    input  logic                         pos_arst,
    input  logic                         wr_en,
    input  logic [taint_pkg::addr_w-1:0] wr_addr,
    input  logic [taint_pkg::addr_w-1:0] wr_addr_taint,
    input  logic [taint_pkg::data_w-1:0] wr_mask,
    input  logic [taint_pkg::data_w-1:0] wr_data_taint,
    input  logic                         wr_en_taint,
    taint_rd_if.memory                   rd
);

    logic [taint_pkg::data_w-1:0] mem_q [taint_pkg::depth];
    logic [taint_pkg::data_w-1:0] rd_data_q;
    logic                         rvalid_q;

    // write port, a tainted address may have hit this word
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            for (int i = 0; i < taint_pkg::depth; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en) begin
            mem_q[wr_addr] <= (wr_data_taint & wr_mask)
                            | {taint_pkg::data_w{|wr_addr_taint}}
                            | {taint_pkg::data_w{wr_en_taint}};
        end
    end

    // registered read sees the contents from before a same-edge write
    always_ff @(posedge pos_clk) begin
        if (rd.req) begin
            rd_data_q <= mem_q[rd.addr]
                       | {taint_pkg::data_w{(|rd.addr_taint) | rd.en_taint}};
        end
    end

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd.req;
        end
    end

    // never stalls
    assign rd.gnt = rd.req;
    assign rd.rvalid = rvalid_q;
    assign rd.data_taint = rd_data_q;

    a_wr_addr_known: assert property (@(posedge pos_clk) disable iff (pos_arst)
        wr_en |-> !$isunknown(wr_addr));

endmodule

// File: taint_pkg.sv
package taint_pkg;

    // datapath and shadow word width
    localparam int data_w = 16;

    // taint memory geometry
    localparam int addr_w = 4;
    localparam int depth = 16;

    // scan count must hold the value depth itself
    localparam int count_w = addr_w + 1;

    // opcode field
    localparam int op_w = 3;

    // two-operand ops
    localparam logic [op_w-1:0] op_and = 3'd0;
    localparam logic [op_w-1:0] op_or = 3'd1;

    // arithmetic, carries spread taint upward
    localparam logic [op_w-1:0] op_add = 3'd2;
    localparam logic [op_w-1:0] op_sub = 3'd3;

    // shift amount taken from b
    localparam logic [op_w-1:0] op_shl = 3'd4;
    localparam logic [op_w-1:0] op_shr = 3'd5;

    // single-bit compare result in bit 0
    localparam logic [op_w-1:0] op_eq = 3'd6;

    // select between a and b with sel
    localparam logic [op_w-1:0] op_mux = 3'd7;

endpackage

// File: taint_rd_arbiter.sv
`timescale 1ns/1ps

module taint_rd_arbiter (
    input  logic          pos_clk,
    input  logic          pos_arst,
    taint_rd_if.arbiter   ld,
    taint_rd_if.arbiter   sc,
    taint_rd_if.requester mem
);

    logic ld_win;
    logic ld_win_q;

    // loads have fixed priority over the scan
    assign ld_win = ld.req;

    assign mem.req = ld.req | sc.req;
    assign mem.addr = ld_win ? ld.addr : sc.addr;
    assign mem.addr_taint = ld_win ? ld.addr_taint : sc.addr_taint;
    assign mem.en_taint = ld_win ? ld.en_taint : sc.en_taint;

    // grant in the request cycle
    assign ld.gnt = ld.req & mem.gnt;
    assign sc.gnt = sc.req & ~ld_win & mem.gnt;

    // remember who owns the reply due next cycle
    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            ld_win_q <= 1'b0;
        end else begin
            ld_win_q <= ld_win;
        end
    end

    assign ld.rvalid = mem.rvalid & ld_win_q;
    assign sc.rvalid = mem.rvalid & ~ld_win_q;

    // data goes to both, rvalid tells who owns it
    assign ld.data_taint = mem.data_taint;
    assign sc.data_taint = mem.data_taint;

    // each reply returns to the requester granted one cycle before
    a_ld_reply: assert property (@(posedge pos_clk) disable iff (pos_arst)
        ld.rvalid |-> $past(ld.gnt));

    a_sc_reply: assert property (@(posedge pos_clk) disable iff (pos_arst)
        sc.rvalid |-> $past(sc.gnt));

endmodule

// File: taint_rd_if.sv
`timescale 1ns/1ps

interface taint_rd_if;

    // request side
    logic                         req;
    logic [taint_pkg::addr_w-1:0] addr;
    logic [taint_pkg::addr_w-1:0] addr_taint;
    logic                         en_taint;

    // reply side
    logic                         gnt;
    logic                         rvalid;
    logic [taint_pkg::data_w-1:0] data_taint;

    // load port or scan engine
    modport requester (
        output req,
        output addr,
        output addr_taint,
        output en_taint,
        input  gnt,
        input  rvalid,
        input  data_taint
    );

    // arbiter facing one requester
    modport arbiter (
        input  req,
        input  addr,
        input  addr_taint,
        input  en_taint,
        output gnt,
        output rvalid,
        output data_taint
    );

    // taint memory read port, always ready
    modport memory (
        input  req,
        input  addr,
        input  addr_taint,
        input  en_taint,
        output gnt,
        output rvalid,
        output data_taint
    );

endinterface

// File: taint_scan.sv
`timescale 1ns/1ps

module taint_scan (
    input  logic                          pos_clk,
    input  logic                          pos_arst,
    input  logic [taint_pkg::depth-1:0]   live_map,
    taint_rd_if.requester                 rd,
    output logic [taint_pkg::count_w-1:0] taint_count,
    output logic                          scan_done
);

    logic [taint_pkg::addr_w-1:0]  addr_q;
    logic [taint_pkg::addr_w-1:0]  rsp_addr_q;
    logic [taint_pkg::count_w-1:0] count_q;
    logic [taint_pkg::count_w-1:0] count_nxt;
    logic                          hit;

    // sweep never stops, clean address and enable
    assign rd.req = 1'b1;
    assign rd.addr = addr_q;
    assign rd.addr_taint = '0;
    assign rd.en_taint = 1'b0;

    // word is tainted and still live
    assign hit = (|rd.data_taint) & live_map[rsp_addr_q];
    assign count_nxt = count_q + {{(taint_pkg::count_w-1){1'b0}}, hit};

    always_ff @(posedge pos_clk or posedge pos_arst) begin
        if (pos_arst) begin
            addr_q <= '0;
            rsp_addr_q <= '0;
            count_q <= '0;
            taint_count <= '0;
            scan_done <= 1'b0;
        end else begin
            scan_done <= 1'b0;
            // advance only when the port was ours
            if (rd.gnt) begin
                rsp_addr_q <= addr_q;
                if (int'(addr_q) == taint_pkg::depth - 1) begin
                    addr_q <= '0;
                end else begin
                    addr_q <= addr_q + 1'b1;
                end
            end
            if (rd.rvalid) begin
                if (int'(rsp_addr_q) == taint_pkg::depth - 1) begin
                    taint_count <= count_nxt;
                    count_q <= '0;
                    scan_done <= 1'b1;
                end else begin
                    count_q <= count_nxt;
                end
            end
        end
    end

    a_count_range: assert property (@(posedge pos_clk) disable iff (pos_arst)
        int'(count_q) <= taint_pkg::depth);

endmodule

// File: taint_shadow_top.sv
`timescale 1ns/1ps

module taint_shadow_top (
    input  logic                          pos_clk,
    input  logic                          pos_arst,
    // exec
    input  logic                          op_valid,
    input  logic [taint_pkg::op_w-1:0]    op,
    input  logic [taint_pkg::data_w-1:0]  a,
    input  logic [taint_pkg::data_w-1:0]  b,
    input  logic [taint_pkg::data_w-1:0]  a_taint,
    input  logic [taint_pkg::data_w-1:0]  b_taint,
    input  logic                          sel,
    input  logic                          sel_taint,
    input  logic                          en_taint,
    output logic [taint_pkg::data_w-1:0]  res,
    output logic [taint_pkg::data_w-1:0]  res_taint,
    // host write
    input  logic                          wr_en,
    input  logic [taint_pkg::addr_w-1:0]  wr_addr,
    input  logic [taint_pkg::addr_w-1:0]  wr_addr_taint,
    input  logic [taint_pkg::data_w-1:0]  wr_mask,
    input  logic [taint_pkg::data_w-1:0]  wr_data_taint,
    input  logic                          wr_en_taint,
    // host load
    input  logic                          ld_req,
    input  logic [taint_pkg::addr_w-1:0]  ld_addr,
    input  logic [taint_pkg::addr_w-1:0]  ld_addr_taint,
    input  logic                          ld_en_taint,
    output logic                          ld_valid,
    output logic [taint_pkg::data_w-1:0]  ld_data_taint,
    // liveness scan
    input  logic [taint_pkg::depth-1:0]   live_map,
    output logic [taint_pkg::count_w-1:0] taint_count,
    output logic                          scan_done
);

    taint_rd_if ld_rd ();
    taint_rd_if sc_rd ();
    taint_rd_if mem_rd ();

    // top ports act as the load requester
    assign ld_rd.req = ld_req;
    assign ld_rd.addr = ld_addr;
    assign ld_rd.addr_taint = ld_addr_taint;
    assign ld_rd.en_taint = ld_en_taint;
    assign ld_valid = ld_rd.rvalid;
    assign ld_data_taint = ld_rd.data_taint;

    taint_exec exec0 (
        .pos_clk, .pos_arst, .op_valid, .op, .a, .b, .a_taint, .b_taint,
        .sel, .sel_taint, .en_taint, .res, .res_taint
    );

    taint_mem mem0 (
        .pos_clk, .pos_arst, .wr_en, .wr_addr, .wr_addr_taint, .wr_mask,
        .wr_data_taint, .wr_en_taint, .rd(mem_rd.memory)
    );

    taint_rd_arbiter arb0 (
        .pos_clk, .pos_arst,
        .ld(ld_rd.arbiter), .sc(sc_rd.arbiter), .mem(mem_rd.requester)
    );

    taint_scan scan0 (
        .pos_clk, .pos_arst, .live_map, .rd(sc_rd.requester),
        .taint_count, .scan_done
    );

endmodule

// File: tb_taint_shadow.sv
`timescale 1ns/1ps

module tb_taint_shadow;

    localparam int p1_cycles = 1500;
    localparam int p2_cycles = 1000;
    localparam int p3_cycles = 400;
    localparam int sweeps = 2;
    localparam int timeout_cycles = 8 + p1_cycles + p2_cycles + p3_cycles
                                  + 4 * taint_pkg::depth * sweeps;

    logic                          pos_clk;
    logic                          pos_arst;
    logic                          op_valid, sel, sel_taint, en_taint;
    logic [taint_pkg::op_w-1:0]    op;
    logic [taint_pkg::data_w-1:0]  a, b, a_taint, b_taint, res, res_taint;
    logic                          wr_en, wr_en_taint, ld_req, ld_en_taint;
    logic [taint_pkg::addr_w-1:0]  wr_addr, wr_addr_taint, ld_addr, ld_addr_taint;
    logic [taint_pkg::data_w-1:0]  wr_mask, wr_data_taint, ld_data_taint;
    logic                          ld_valid, scan_done;
    logic [taint_pkg::depth-1:0]   live_map;
    logic [taint_pkg::count_w-1:0] taint_count, last_count;

    // reference model state
    logic [31:0]                  lfsr = 32'h49c3_b43a;
    logic [taint_pkg::data_w-1:0] m_res, m_res_taint;
    logic [taint_pkg::data_w-1:0] m_mem [taint_pkg::depth];
    logic                         prev_done, count_armed;
    int                           value_errs, proto_errs, done_seen, cycle_cnt, n;

    taint_shadow_top dut0 (.*);

    initial begin
        pos_clk = 1'b0;
        forever #20 pos_clk = ~pos_clk;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic int rand_int(input int bits);
        int r;
        r = 0;
        for (int i = 0; i < bits; i++) begin
            r = r * 2 + (rand_bit() ? 1 : 0);
        end
        return r;
    endfunction

    function automatic logic [taint_pkg::data_w-1:0] rand_word();
        logic [taint_pkg::data_w-1:0] w;
        for (int i = 0; i < taint_pkg::data_w; i++) begin
            w[i] = rand_bit();
        end
        return w;
    endfunction

    function automatic logic [taint_pkg::addr_w-1:0] rand_addr();
        logic [taint_pkg::addr_w-1:0] w;
        for (int i = 0; i < taint_pkg::addr_w; i++) begin
            w[i] = rand_bit();
        end
        return w;
    endfunction

    function automatic logic [taint_pkg::depth-1:0] rand_live();
        logic [taint_pkg::depth-1:0] w;
        for (int i = 0; i < taint_pkg::depth; i++) begin
            w[i] = rand_bit();
        end
        return w;
    endfunction

    // clean, one bit, or sparse
    function automatic logic [taint_pkg::data_w-1:0] rand_taint();
        logic [taint_pkg::data_w-1:0] t;
        int k;
        k = rand_int(2);
        t = '0;
        if (k == 1) begin
            t[rand_addr()] = 1'b1;
        end else if (k > 1) begin
            t = rand_word() & rand_word();
        end
        return t;
    endfunction

    function automatic logic [taint_pkg::data_w-1:0] model_value(
        input logic [taint_pkg::op_w-1:0] o, input logic [taint_pkg::data_w-1:0] x, z,
        input logic s);
        logic [taint_pkg::data_w-1:0] v;
        v = '0;
        case (o)
            taint_pkg::op_and: v = x & z;
            taint_pkg::op_or:  v = x | z;
            taint_pkg::op_add: v = x + z;
            taint_pkg::op_sub: v = x - z;
            taint_pkg::op_shl: v = x << z;
            taint_pkg::op_shr: v = x >> z;
            taint_pkg::op_eq:  v[0] = (x == z);
            default:           v = s ? z : x;
        endcase
        return v;
    endfunction

    function automatic logic [taint_pkg::data_w-1:0] model_taint(
        input logic [taint_pkg::op_w-1:0] o, input logic [taint_pkg::data_w-1:0] x, z, xt, zt,
        input logic s, st);
        logic [taint_pkg::data_w-1:0] t, both;
        both = xt | zt;
        t = '0;
        case (o)
            taint_pkg::op_and: t = (xt & (z | zt)) | (zt & (x | xt));
            taint_pkg::op_or:  t = (xt & (~z | zt)) | (zt & (~x | xt));
            taint_pkg::op_add: t = (((x & ~xt) + (z & ~zt)) ^ ((x | xt) + (z | zt))) | both;
            taint_pkg::op_sub: t = (((x & ~xt) - (z & ~zt)) ^ ((x | xt) - (z | zt))) | both;
            taint_pkg::op_shl: t = (zt != '0) ? '1 : (xt << z);
            taint_pkg::op_shr: t = (zt != '0) ? '1 : (xt >> z);
            taint_pkg::op_eq:  t[0] = (both != '0) && (((x ^ z) & ~both) == '0);
            default: begin
                t = s ? zt : xt;
                if (st) begin
                    t = t | (x ^ z);
                end
            end
        endcase
        return t;
    endfunction

    task automatic check_word(input logic [taint_pkg::data_w-1:0] got,
                              input logic [taint_pkg::data_w-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input logic [taint_pkg::count_w-1:0] got,
                               input logic [taint_pkg::count_w-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errs++;
        end
    endtask

    function automatic logic [taint_pkg::count_w-1:0] expected_count();
        logic [taint_pkg::count_w-1:0] c;
        c = '0;
        for (int i = 0; i < taint_pkg::depth; i++) begin
            if (m_mem[i] != '0 && live_map[i]) begin
                c++;
            end
        end
        return c;
    endfunction

    task automatic drive_exec();
        int kind;
        kind = rand_int(3);
        for (int i = 0; i < taint_pkg::op_w; i++) begin
            op[i] = rand_bit();
        end
        a = rand_word();
        a_taint = rand_taint();
        b_taint = rand_taint();
        b = rand_word();
        // small shift amounts, some past the word width
        if (op == taint_pkg::op_shl || op == taint_pkg::op_shr) begin
            b = b >> (taint_pkg::data_w - 5);
        end else if (op == taint_pkg::op_eq && rand_bit()) begin
            b = a ^ a_taint;
        end
        sel = rand_bit();
        sel_taint = rand_bit();
        // kinds 0..5 issue an op, 6 only taints the enable, 7 idles
        op_valid = (kind < 6);
        en_taint = (kind == 6);
    endtask

    task automatic drive_mem(input logic wr_on, input logic dense);
        wr_en = wr_on & rand_bit();
        wr_addr = rand_addr();
        wr_addr_taint = (rand_int(3) == 0) ? rand_addr() : '0;
        wr_en_taint = (rand_int(4) == 0);
        wr_mask = rand_word();
        wr_data_taint = rand_taint();
        ld_req = dense ? (rand_int(2) != 0) : rand_bit();
        ld_addr = rand_addr();
        ld_addr_taint = (rand_int(3) == 0) ? rand_addr() : '0;
        ld_en_taint = (rand_int(3) == 0);
    endtask

    // inputs still hold what the DUT sampled on this edge
    task automatic step_and_check();
        logic [taint_pkg::data_w-1:0] y, diff, ld_exp;
        @(posedge pos_clk);
        #2;
        y = model_value(op, a, b, sel);
        diff = en_taint ? (y ^ m_res) : '0;
        if (op_valid) begin
            m_res_taint = model_taint(op, a, b, a_taint, b_taint, sel, sel_taint) | diff;
            m_res = y;
        end else begin
            m_res_taint = m_res_taint | diff;
        end
        check_word(res, m_res, "res");
        check_word(res_taint, m_res_taint, "res_taint");
        // load sees the word before a same-edge write
        ld_exp = m_mem[ld_addr];
        if (ld_addr_taint != '0 || ld_en_taint) begin
            ld_exp = '1;
        end
        if (ld_req && ld_valid !== 1'b1) begin
            $display("ld_valid missing one cycle after a load request at %0t", $time);
            proto_errs++;
        end else if (ld_req) begin
            check_word(ld_data_taint, ld_exp, "ld_data_taint");
        end else if (ld_valid !== 1'b0) begin
            $display("ld_valid without a load request at %0t", $time);
            proto_errs++;
        end
        if (wr_en) begin
            m_mem[wr_addr] = (wr_addr_taint != '0 || wr_en_taint) ? '1
                                                                 : (wr_data_taint & wr_mask);
        end
        if (scan_done === 1'b1) begin
            if (prev_done) begin
                $display("scan_done stayed high for two cycles at %0t", $time);
                proto_errs++;
            end
            if (count_armed) begin
                done_seen++;
                if (done_seen >= 2) begin
                    check_count(taint_count, expected_count(), "taint_count");
                end
            end
        end else if (taint_count !== last_count) begin
            $display("taint_count changed without scan_done at %0t", $time);
            proto_errs++;
        end
        prev_done = (scan_done === 1'b1);
        last_count = taint_count;
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge pos_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, only %0d scan_done pulses seen",
                 cycle_cnt, done_seen);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        pos_arst = 1'b1;
        op_valid = 1'b0;
        op = '0;
        a = '0;
        b = '0;
        a_taint = '0;
        b_taint = '0;
        sel = 1'b0;
        sel_taint = 1'b0;
        en_taint = 1'b0;
        drive_mem(1'b0, 1'b0);
        ld_req = 1'b0;
        live_map = '0;
        m_res = '0;
        m_res_taint = '0;
        for (int i = 0; i < taint_pkg::depth; i++) begin
            m_mem[i] = '0;
        end
        prev_done = 1'b0;
        count_armed = 1'b0;
        last_count = '0;
        repeat (8) @(posedge pos_clk);
        #2;
        pos_arst = 1'b0;
        // exec with loads of a clean memory, then writes and loads
        for (int i = 0; i < p1_cycles + p2_cycles; i++) begin
            drive_exec();
            drive_mem(i >= p1_cycles, 1'b0);
            live_map = rand_live();
            step_and_check();
        end
        // writes stopped, liveness fixed, loads turn dense halfway
        live_map = rand_live();
        count_armed = 1'b1;
        done_seen = 0;
        n = 0;
        while (n < p3_cycles || done_seen < 2) begin
            drive_exec();
            drive_mem(1'b0, n >= p3_cycles / 2);
            step_and_check();
            n++;
        end
        $display("summary: %0d value errors, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
taint_pkg.sv
taint_rd_if.sv
taint_exec.sv
taint_mem.sv
taint_rd_arbiter.sv
taint_scan.sv
taint_shadow_top.sv
tb_taint_shadow.sv
